//--- common/scaler_pkg.sv
`default_nettype none

package scaler_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------
    localparam int PIXEL_W    = 8;
    localparam int COORD_W    = 11;
    localparam int FRAC_W     = 16;
    localparam int ROW_SLOT_W = 10;    // 1024 pixel stride per row slot

    typedef logic [PIXEL_W-1:0]          pixel_t;
    typedef logic [COORD_W-1:0]          coord_t;
    typedef logic [COORD_W+FRAC_W-1:0]   fix_t;          // integer part over 16 fraction bits
    typedef logic [FRAC_W:0]             weight_t;       // up to 1.0 inclusive
    typedef logic [2*FRAC_W+1:0]         tap_weight_t;
    typedef logic [ROW_SLOT_W+1:0]       ram_addr_t;     // slot bits above the column
    typedef logic [PIXEL_W+2*FRAC_W+3:0] blend_sum_t;

    // step between neighbouring destination pixels, in source units
    function automatic logic [FRAC_W:0] calc_ratio(
        input int unsigned src,
        input int unsigned dst
    );
        logic [63:0] scaled;
        scaled = 64'(src) << FRAC_W;
        return (FRAC_W+1)'(scaled / 64'(dst));
    endfunction

endpackage

`default_nettype wire

//--- line_buffer/line_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_bank_ram (
    input  wire                        clk_in2,
    input  wire                        we,
    input  wire scaler_pkg::ram_addr_t wr_addr,
    input  wire scaler_pkg::pixel_t    wr_data,
    input  wire scaler_pkg::ram_addr_t rd_addr,
    output scaler_pkg::pixel_t         rd_data
);

    localparam int DEPTH = 1 << $bits(scaler_pkg::ram_addr_t);

    scaler_pkg::pixel_t mem [DEPTH];    // four row slots of 1024 pixels

    always_ff @(posedge clk_in2)
    begin
        if (we)
        begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];        // registered read
    end

endmodule

`default_nettype wire

//--- line_buffer/line_writer.sv
`timescale 1ns/1ps
`default_nettype none

module line_writer #(
    parameter int SRC_W = 640
) (
    input  wire                     clk_in2,
    input  wire                     rst_n,
    input  wire                     in_vsync,
    input  wire                     in_href,
    input  wire scaler_pkg::pixel_t in_gray,
    output scaler_pkg::ram_addr_t   wr_addr,
    output scaler_pkg::pixel_t      wr_data,
    output logic                    even_we,
    output logic                    odd_we,
    output scaler_pkg::coord_t      rows_done,
    output logic                    frame_start
);

    scaler_pkg::coord_t col_cnt;
    logic               vsync_q;
    logic               pix_valid;
    logic               last_pix;

    assign pix_valid = in_vsync & in_href;
    assign last_pix  = pix_valid && (col_cnt == scaler_pkg::coord_t'(SRC_W - 1));

    // -------------------------------------------------------------------------
    // column and row counters
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            col_cnt     <= '0;
            rows_done   <= '0;
            vsync_q     <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            vsync_q     <= in_vsync;
            frame_start <= in_vsync & ~vsync_q;    // rising edge of the frame
            col_cnt     <= pix_valid ? col_cnt + 1'b1 : '0;
            if (!in_vsync)
                rows_done <= '0;
            else if (last_pix)
                rows_done <= rows_done + 1'b1;     // row index of the next line
        end
    end

    // -------------------------------------------------------------------------
    // write port, one cycle behind the sample
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            even_we <= 1'b0;
            odd_we  <= 1'b0;
        end
        else
        begin
            even_we <= pix_valid & ~rows_done[0];
            odd_we  <= pix_valid & rows_done[0];
        end
    end

    always_ff @(posedge clk_in2)
    begin
        wr_data <= in_gray;
        wr_addr <= {rows_done[2:1], col_cnt[scaler_pkg::ROW_SLOT_W-1:0]};   // slot, column
    end

    // a longer line would spill into the next row slot
    assert property (@(posedge clk_in2) disable iff (!rst_n)
        in_href |-> (col_cnt < scaler_pkg::coord_t'(SRC_W)))
    else $error("line_writer: source line longer than SRC_W");

endmodule

`default_nettype wire

//--- verilog/scale_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scale_sequencer #(
    parameter int SRC_W = 640,
    parameter int SRC_H = 480,
    parameter int DST_W = 320,
    parameter int DST_H = 240
) (
    input  wire                     clk_in2,
    input  wire                     rst_n,
    input  wire                     frame_start,
    input  wire scaler_pkg::coord_t rows_done,
    output scaler_pkg::fix_t        x_pos,
    output scaler_pkg::fix_t        y_pos,
    output logic                    line,
    output logic                    frame
);

    localparam logic [scaler_pkg::FRAC_W:0] X_RATIO = scaler_pkg::calc_ratio(SRC_W, DST_W);
    localparam logic [scaler_pkg::FRAC_W:0] Y_RATIO = scaler_pkg::calc_ratio(SRC_H, DST_H);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ROW_WAIT,
        S_ROW_ISSUE,
        S_ROW_ADVANCE
    } state_t;

    state_t             state;
    scaler_pkg::coord_t x_cnt;
    scaler_pkg::coord_t y_cnt;
    scaler_pkg::coord_t x_int;
    scaler_pkg::coord_t y_int;
    logic               rows_ready;
    logic               last_col;
    logic               last_row;

    assign x_int    = x_pos[scaler_pkg::FRAC_W +: scaler_pkg::COORD_W];
    assign y_int    = y_pos[scaler_pkg::FRAC_W +: scaler_pkg::COORD_W];
    assign last_col = (x_cnt == scaler_pkg::coord_t'(DST_W - 1));
    assign last_row = (y_cnt == scaler_pkg::coord_t'(DST_H - 1));

    // both source rows in the ring, or the whole frame is in
    assign rows_ready = (rows_done > y_int + scaler_pkg::coord_t'(1))
                     || (rows_done == scaler_pkg::coord_t'(SRC_H));

    // -------------------------------------------------------------------------
    // row FSM and coordinate accumulators
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            x_cnt <= '0;
            y_cnt <= '0;
            x_pos <= '0;
            y_pos <= '0;
            line  <= 1'b0;
            frame <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (frame_start)
                    begin
                        y_pos <= '0;
                        y_cnt <= '0;
                        state <= S_ROW_WAIT;
                    end
                end
                S_ROW_WAIT:
                begin
                    if (rows_ready)
                    begin
                        x_pos <= '0;
                        x_cnt <= '0;
                        line  <= 1'b1;
                        frame <= 1'b1;         // rises with the first pixel of row 0
                        state <= S_ROW_ISSUE;
                    end
                end
                S_ROW_ISSUE:
                begin
                    x_pos <= x_pos + scaler_pkg::fix_t'(X_RATIO);
                    x_cnt <= x_cnt + 1'b1;
                    if (last_col)
                    begin
                        line  <= 1'b0;
                        frame <= ~last_row;
                        state <= S_ROW_ADVANCE;
                    end
                end
                S_ROW_ADVANCE:
                begin
                    y_pos <= y_pos + scaler_pkg::fix_t'(Y_RATIO);
                    y_cnt <= y_cnt + 1'b1;
                    state <= last_row ? S_IDLE : S_ROW_WAIT;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // mapped column stays inside the source line
    assert property (@(posedge clk_in2) disable iff (!rst_n)
        line |-> (x_int < scaler_pkg::coord_t'(SRC_W)))
    else $error("scale_sequencer: x coordinate beyond source width");

endmodule

`default_nettype wire

//--- verilog/tap_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tap_fetch #(
    parameter int SRC_W = 640,
    parameter int SRC_H = 480
) (
    input  wire                     clk_in2,
    input  wire                     rst_n,
    input  wire scaler_pkg::fix_t   x_pos,
    input  wire scaler_pkg::fix_t   y_pos,
    input  wire                     line,
    input  wire                     frame,
    output scaler_pkg::ram_addr_t   even_left_rd_addr,
    output scaler_pkg::ram_addr_t   even_right_rd_addr,
    output scaler_pkg::ram_addr_t   odd_left_rd_addr,
    output scaler_pkg::ram_addr_t   odd_right_rd_addr,
    input  wire scaler_pkg::pixel_t even_left_rd_data,
    input  wire scaler_pkg::pixel_t even_right_rd_data,
    input  wire scaler_pkg::pixel_t odd_left_rd_data,
    input  wire scaler_pkg::pixel_t odd_right_rd_data,
    output scaler_pkg::pixel_t      p00,
    output scaler_pkg::pixel_t      p01,
    output scaler_pkg::pixel_t      p10,
    output scaler_pkg::pixel_t      p11,
    output scaler_pkg::tap_weight_t w00,
    output scaler_pkg::tap_weight_t w01,
    output scaler_pkg::tap_weight_t w10,
    output scaler_pkg::tap_weight_t w11,
    output logic                    tap_line,
    output logic                    tap_frame
);

    localparam scaler_pkg::weight_t ONE = scaler_pkg::weight_t'(1 << scaler_pkg::FRAC_W);

    scaler_pkg::coord_t               x_int_c1, y_int_c1;
    scaler_pkg::weight_t              a_c1, na_c1, b_c1, nb_c1;
    scaler_pkg::ram_addr_t            odd_base, even_base;
    scaler_pkg::tap_weight_t [3:0]    w_c2, w_c3, w_c4;    // order 00, 01, 10, 11
    logic [1:0]                       odd_top_q;           // c2, c3
    logic [2:0]                       right_q, bottom_q;   // c2 to c4
    scaler_pkg::pixel_t               top_l, top_r, bot_l, bot_r;
    logic [4:0]                       line_q, frame_q;

    // -------------------------------------------------------------------------
    // c1 and c2: split coordinates, weights, read addresses
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        x_int_c1 <= x_pos[scaler_pkg::FRAC_W +: scaler_pkg::COORD_W];
        y_int_c1 <= y_pos[scaler_pkg::FRAC_W +: scaler_pkg::COORD_W];
        a_c1     <= {1'b0, x_pos[scaler_pkg::FRAC_W-1:0]};
        na_c1    <= ONE - {1'b0, x_pos[scaler_pkg::FRAC_W-1:0]};
        b_c1     <= {1'b0, y_pos[scaler_pkg::FRAC_W-1:0]};
        nb_c1    <= ONE - {1'b0, y_pos[scaler_pkg::FRAC_W-1:0]};
    end

    // odd top row puts the bottom row in the next even slot
    assign odd_base  = {y_int_c1[2:1], x_int_c1[scaler_pkg::ROW_SLOT_W-1:0]};
    assign even_base = odd_base + {y_int_c1[0], scaler_pkg::ROW_SLOT_W'(0)};

    always_ff @(posedge clk_in2)
    begin
        w_c2[0]            <= na_c1 * nb_c1;
        w_c2[1]            <= a_c1 * nb_c1;
        w_c2[2]            <= na_c1 * b_c1;
        w_c2[3]            <= a_c1 * b_c1;
        even_left_rd_addr  <= even_base;
        even_right_rd_addr <= even_base + 1'b1;
        odd_left_rd_addr   <= odd_base;
        odd_right_rd_addr  <= odd_base + 1'b1;
        odd_top_q <= {odd_top_q[0], y_int_c1[0]};
        right_q   <= {right_q[1:0], x_int_c1 == scaler_pkg::coord_t'(SRC_W - 1)};
        bottom_q  <= {bottom_q[1:0], y_int_c1 == scaler_pkg::coord_t'(SRC_H - 1)};
        w_c3      <= w_c2;
        w_c4      <= w_c3;
    end

    // -------------------------------------------------------------------------
    // c4 lane swap, c5 edge replication
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (odd_top_q[1])
        begin
            top_l <= odd_left_rd_data;
            top_r <= odd_right_rd_data;
            bot_l <= even_left_rd_data;
            bot_r <= even_right_rd_data;
        end
        else
        begin
            top_l <= even_left_rd_data;
            top_r <= even_right_rd_data;
            bot_l <= odd_left_rd_data;
            bot_r <= odd_right_rd_data;
        end
        p00 <= top_l;
        p01 <= right_q[2] ? top_l : top_r;        // last column
        p10 <= bottom_q[2] ? top_l : bot_l;       // last row
        case ({right_q[2], bottom_q[2]})
            2'b00:   p11 <= bot_r;
            2'b01:   p11 <= top_r;
            2'b10:   p11 <= bot_l;
            default: p11 <= top_l;
        endcase
        w00 <= w_c4[0];
        w01 <= w_c4[1];
        w10 <= w_c4[2];
        w11 <= w_c4[3];
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            line_q  <= '0;
            frame_q <= '0;
        end
        else
        begin
            line_q  <= {line_q[3:0], line};
            frame_q <= {frame_q[3:0], frame};
        end
    end

    assign tap_line  = line_q[4];
    assign tap_frame = frame_q[4];

endmodule

`default_nettype wire

//--- verilog/blend_unit.sv
`timescale 1ns/1ps
`default_nettype none

module blend_unit (
    input  wire                          clk_in2,
    input  wire                          rst_n,
    input  wire scaler_pkg::pixel_t      p00,
    input  wire scaler_pkg::pixel_t      p01,
    input  wire scaler_pkg::pixel_t      p10,
    input  wire scaler_pkg::pixel_t      p11,
    input  wire scaler_pkg::tap_weight_t w00,
    input  wire scaler_pkg::tap_weight_t w01,
    input  wire scaler_pkg::tap_weight_t w10,
    input  wire scaler_pkg::tap_weight_t w11,
    input  wire                          tap_line,
    input  wire                          tap_frame,
    output scaler_pkg::pixel_t           out_gray,
    output logic                         out_href,
    output logic                         out_vsync
);

    localparam int PROD_W = scaler_pkg::PIXEL_W + $bits(scaler_pkg::tap_weight_t);
    localparam int FW2    = 2 * scaler_pkg::FRAC_W;             // fraction bits of the sum
    localparam int INT_W  = $bits(scaler_pkg::blend_sum_t) - FW2;

    logic [PROD_W-1:0]      prod00, prod01, prod10, prod11;
    logic [PROD_W:0]        pair_top, pair_bot;
    scaler_pkg::blend_sum_t total;
    logic [INT_W-1:0]       rounded;
    logic [3:0]             href_q, vsync_q;

    // round half up at bit 31
    assign rounded = total[FW2 +: INT_W] + INT_W'(total[FW2-1]);

    always_ff @(posedge clk_in2)
    begin
        prod00   <= p00 * w00;
        prod01   <= p01 * w01;
        prod10   <= p10 * w10;
        prod11   <= p11 * w11;
        pair_top <= prod00 + prod01;
        pair_bot <= prod10 + prod11;
        total    <= pair_top + pair_bot;
        if (|rounded[INT_W-1:scaler_pkg::PIXEL_W])
            out_gray <= '1;                                  // saturate to 255
        else
            out_gray <= rounded[scaler_pkg::PIXEL_W-1:0];
    end

    // strobes follow the four pipeline stages
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            href_q  <= '0;
            vsync_q <= '0;
        end
        else
        begin
            href_q  <= {href_q[2:0], tap_line};
            vsync_q <= {vsync_q[2:0], tap_frame};
        end
    end

    assign out_href  = href_q[3];
    assign out_vsync = vsync_q[3];

endmodule

`default_nettype wire

//--- verilog/bilinear_scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

module bilinear_scaler_top #(
    parameter int SRC_W = 640,
    parameter int SRC_H = 480,
    parameter int DST_W = 320,
    parameter int DST_H = 240
) (
    input  wire                     clk_in2,
    input  wire                     rst_n,
    input  wire                     in_vsync,
    input  wire                     in_href,
    input  wire scaler_pkg::pixel_t in_gray,
    output logic                    out_vsync,
    output logic                    out_href,
    output scaler_pkg::pixel_t      out_gray
);

    // row store
    scaler_pkg::ram_addr_t   wr_addr;
    scaler_pkg::pixel_t      wr_data;
    logic                    even_we, odd_we, frame_start;
    scaler_pkg::coord_t      rows_done;

    // coordinate and tap path
    scaler_pkg::fix_t        x_pos, y_pos;
    logic                    seq_line, seq_frame, tap_line, tap_frame;
    scaler_pkg::ram_addr_t   even_left_rd_addr, even_right_rd_addr;
    scaler_pkg::ram_addr_t   odd_left_rd_addr, odd_right_rd_addr;
    scaler_pkg::pixel_t      even_left_rd_data, even_right_rd_data;
    scaler_pkg::pixel_t      odd_left_rd_data, odd_right_rd_data;
    scaler_pkg::pixel_t      p00, p01, p10, p11;
    scaler_pkg::tap_weight_t w00, w01, w10, w11;

    line_writer #(.SRC_W(SRC_W)) line_writer_i (
        .clk_in2(clk_in2), .rst_n(rst_n),
        .in_vsync(in_vsync), .in_href(in_href), .in_gray(in_gray),
        .wr_addr(wr_addr), .wr_data(wr_data), .even_we(even_we), .odd_we(odd_we),
        .rows_done(rows_done), .frame_start(frame_start)
    );

    // two copies per bank give left and right taps in one cycle
    line_bank_ram even_left_i (
        .clk_in2(clk_in2), .we(even_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(even_left_rd_addr), .rd_data(even_left_rd_data)
    );
    line_bank_ram even_right_i (
        .clk_in2(clk_in2), .we(even_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(even_right_rd_addr), .rd_data(even_right_rd_data)
    );
    line_bank_ram odd_left_i (
        .clk_in2(clk_in2), .we(odd_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(odd_left_rd_addr), .rd_data(odd_left_rd_data)
    );
    line_bank_ram odd_right_i (
        .clk_in2(clk_in2), .we(odd_we), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(odd_right_rd_addr), .rd_data(odd_right_rd_data)
    );

    scale_sequencer #(
        .SRC_W(SRC_W), .SRC_H(SRC_H), .DST_W(DST_W), .DST_H(DST_H)
    ) scale_sequencer_i (
        .clk_in2(clk_in2), .rst_n(rst_n),
        .frame_start(frame_start), .rows_done(rows_done),
        .x_pos(x_pos), .y_pos(y_pos), .line(seq_line), .frame(seq_frame)
    );

    tap_fetch #(.SRC_W(SRC_W), .SRC_H(SRC_H)) tap_fetch_i (
        .clk_in2(clk_in2), .rst_n(rst_n),
        .x_pos(x_pos), .y_pos(y_pos), .line(seq_line), .frame(seq_frame),
        .even_left_rd_addr(even_left_rd_addr), .even_right_rd_addr(even_right_rd_addr),
        .odd_left_rd_addr(odd_left_rd_addr), .odd_right_rd_addr(odd_right_rd_addr),
        .even_left_rd_data(even_left_rd_data), .even_right_rd_data(even_right_rd_data),
        .odd_left_rd_data(odd_left_rd_data), .odd_right_rd_data(odd_right_rd_data),
        .p00(p00), .p01(p01), .p10(p10), .p11(p11),
        .w00(w00), .w01(w01), .w10(w10), .w11(w11),
        .tap_line(tap_line), .tap_frame(tap_frame)
    );

    blend_unit blend_unit_i (
        .clk_in2(clk_in2), .rst_n(rst_n),
        .p00(p00), .p01(p01), .p10(p10), .p11(p11),
        .w00(w00), .w01(w01), .w10(w10), .w11(w11),
        .tap_line(tap_line), .tap_frame(tap_frame),
        .out_gray(out_gray), .out_href(out_href), .out_vsync(out_vsync)
    );

endmodule

`default_nettype wire

//--- test/tb_bilinear_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bilinear_scaler;

    localparam int SRC_W      = 16;
    localparam int SRC_H      = 12;
    localparam int DST_W      = 12;
    localparam int DST_H      = 9;
    localparam int MIN_GAP    = 4;
    localparam int MAX_GAP    = 12;
    localparam int NUM_FRAMES = 6;
    localparam int TIMEOUT    = NUM_FRAMES * (SRC_H * (SRC_W + MAX_GAP) + 200) + 100;

    // source step per destination pixel in 16-bit fixed point
    localparam longint X_STEP = (longint'(SRC_W) << 16) / DST_W;
    localparam longint Y_STEP = (longint'(SRC_H) << 16) / DST_H;

    logic       clk_in2 = 1'b0;
    logic       rst_n;
    logic       in_vsync;
    logic       in_href;
    logic [7:0] in_gray;
    logic       out_vsync;
    logic       out_href;
    logic [7:0] out_gray;

    logic [7:0] img [SRC_H][SRC_W];     // current source frame
    int         exp_q [$];              // expected pixels in raster order
    string      cur_test    = "reset";
    int         cycle_cnt   = 0;
    int         frames_done = 0;
    int         run_len     = 0;
    int         run_cnt     = 0;
    logic       href_prev   = 1'b0;
    logic       vsync_prev  = 1'b0;

    bilinear_scaler_top #(
        .SRC_W(SRC_W), .SRC_H(SRC_H), .DST_W(DST_W), .DST_H(DST_H)
    ) bilinear_scaler_top_i (
        .clk_in2(clk_in2), .rst_n(rst_n),
        .in_vsync(in_vsync), .in_href(in_href), .in_gray(in_gray),
        .out_vsync(out_vsync), .out_href(out_href), .out_gray(out_gray)
    );

    always #5 clk_in2 = ~clk_in2;

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    task automatic check(input string name, input longint expected, input longint actual);
        if (expected != actual)
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------------------------------
    // reference model and stimulus
    // ------------------------------------------------------------------------
    function automatic int model_pixel(input int x, input int y);
        longint fx, fy, a, b, sum, res;
        int     xi, yi, x1, y1;
        fx  = longint'(x) * X_STEP;
        fy  = longint'(y) * Y_STEP;
        xi  = int'(fx >> 16);
        yi  = int'(fy >> 16);
        a   = fx & 64'hffff;
        b   = fy & 64'hffff;
        x1  = (xi == SRC_W - 1) ? xi : xi + 1;     // replicate last column
        y1  = (yi == SRC_H - 1) ? yi : yi + 1;     // replicate last row
        sum = longint'(img[yi][xi]) * (65536 - a) * (65536 - b)
            + longint'(img[yi][x1]) * a * (65536 - b)
            + longint'(img[y1][xi]) * (65536 - a) * b
            + longint'(img[y1][x1]) * a * b;
        res = (sum >> 32) + ((sum >> 31) & 1);
        return (res > 255) ? 255 : int'(res);
    endfunction

    // 0 random, 1 dark with bright last column and row, 2 all white
    task automatic fill_image(input int mode);
        for (int r = 0; r < SRC_H; r++)
        begin
            for (int c = 0; c < SRC_W; c++)
            begin
                case (mode)
                    0:       img[r][c] = 8'($urandom);
                    1:       img[r][c] = (r == SRC_H - 1 || c == SRC_W - 1) ?
                                         8'd255 : 8'($urandom % 64);
                    default: img[r][c] = 8'd255;
                endcase
            end
        end
    endtask

    task automatic drive_frame(input int mode, input string name, input int idle_cycles);
        int gap;
        int target;
        fill_image(mode);
        cur_test = name;
        for (int y = 0; y < DST_H; y++)
        begin
            for (int x = 0; x < DST_W; x++)
            begin
                exp_q.push_back(model_pixel(x, y));
            end
        end
        target = frames_done + 1;
        @(posedge clk_in2);
        in_vsync <= 1'b1;
        repeat (2) @(posedge clk_in2);
        for (int r = 0; r < SRC_H; r++)
        begin
            for (int c = 0; c < SRC_W; c++)
            begin
                @(posedge clk_in2);
                in_href <= 1'b1;
                in_gray <= img[r][c];
            end
            gap = MIN_GAP + int'($urandom % (MAX_GAP - MIN_GAP + 1));
            @(posedge clk_in2);
            in_href <= 1'b0;
            in_gray <= '0;
            repeat (gap - 1) @(posedge clk_in2);
        end
        // keep the frame open until the scaled frame is out
        while (frames_done < target)
            @(posedge clk_in2);
        in_vsync <= 1'b0;
        repeat (idle_cycles) @(posedge clk_in2);
    endtask

    // ------------------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------------------
    always @(negedge clk_in2)
    begin
        int expected;
        if (rst_n)
        begin
            if (out_href)
            begin
                check({cur_test, " href inside vsync"}, 1, out_vsync);
                if (exp_q.size() == 0)
                    report_error("output pixel arrived while none was expected");
                else
                begin
                    expected = exp_q.pop_front();
                    check(cur_test, expected, out_gray);
                end
                run_len = run_len + 1;
            end
            else if (href_prev)
            begin
                check({cur_test, " line length"}, DST_W, run_len);
                run_len = 0;
                run_cnt = run_cnt + 1;
            end
            if (vsync_prev && !out_vsync)   // end of an output frame
            begin
                check({cur_test, " line count"}, DST_H, run_cnt);
                run_cnt     = 0;
                frames_done = frames_done + 1;
            end
            href_prev  = out_href;
            vsync_prev = out_vsync;
        end
    end

    always @(posedge clk_in2)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT)
            report_error($sformatf("no progress, run stopped after %0d cycles", TIMEOUT));
    end

    initial
    begin
        void'($urandom(53));
        rst_n    = 1'b0;
        in_vsync = 1'b0;
        in_href  = 1'b0;
        in_gray  = '0;
        repeat (4) @(posedge clk_in2);
        rst_n <= 1'b1;

        cur_test = "idle after reset";
        repeat (50)
        begin
            @(negedge clk_in2);
            check("idle out_vsync", 0, out_vsync);
            check("idle out_href", 0, out_href);
        end

        drive_frame(0, "random image", 8);
        drive_frame(1, "bright edges", 8);
        drive_frame(2, "all 255", 8);
        for (int i = 0; i < 3; i++)
        begin
            drive_frame(0, $sformatf("back-to-back %0d", i), 2);   // short vsync gap
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/scaler_pkg.sv
line_buffer/line_bank_ram.sv
line_buffer/line_writer.sv
verilog/scale_sequencer.sv
verilog/tap_fetch.sv
verilog/blend_unit.sv
verilog/bilinear_scaler_top.sv
test/tb_bilinear_scaler.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the bilinear scaler testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_bilinear_scaler

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f build.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
